// ==== rtl/rv_pkg.sv ====
// RV64 decode stage definitions
package rv_pkg;

  localparam int XLEN   = 64;
  localparam int INST_W = 32;
  localparam int GPR_AW = 5;
  localparam int CSR_AW = 12;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [CSR_AW-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_AW-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_AW-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_AW-1:0] CSR_MCAUSE  = 12'h342;

  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR
  } csr_op_e;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic       alu_src1_sel;  // 0 rs1, 1 pc
    logic [1:0] alu_src2_sel;  // 0 rs2, 1 imm, 2 constant 4
    logic       word_cut;
    alu_op_e    alu_op;
    logic       gpr_wen;
    logic       csr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;        // funct3
    logic       csr_inst_sel;  // csr read data goes to rd
    csr_op_e    csr_op;
    logic       ebreak;
    logic       invalid;
  } decode_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]   rs1data;
    logic [XLEN-1:0]   rs2data;
    logic [XLEN-1:0]   csrrdata;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc;
    logic [GPR_AW-1:0] rd;
    logic [CSR_AW-1:0] csr;
    decode_ctrl_t      ctrl;
  } ds_to_es_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic              gpr_wen;
    logic [GPR_AW-1:0] gpr_waddr;
    logic [XLEN-1:0]   gpr_wdata;
    logic              csr_wen;
    logic [CSR_AW-1:0] csr_waddr;
    logic [XLEN-1:0]   csr_wdata;
  } ws_to_rf_t;

  // zero means no destination
  typedef struct packed {
    logic [GPR_AW-1:0] gpr_rd;
    logic [CSR_AW-1:0] csr_rd;
  } stage_rd_t;

endpackage

// ==== rtl/rv_decoder.sv ====
// RV64I and Zicsr instruction decoder
`timescale 1ns/10ps

module rv_decoder (
  input  logic [rv_pkg::INST_W-1:0] i_inst,
  output logic [rv_pkg::GPR_AW-1:0] o_rs1,
  output logic [rv_pkg::GPR_AW-1:0] o_rs2,
  output logic [rv_pkg::GPR_AW-1:0] o_rd,
  output logic [rv_pkg::CSR_AW-1:0] o_csr,
  output logic [rv_pkg::XLEN-1:0]   o_imm,
  output rv_pkg::decode_ctrl_t      o_ctrl,
  output logic                      o_bren,
  output logic [2:0]                o_brfunc,
  output logic                      o_jal,
  output logic                      o_jalr,
  output logic                      o_ecall,
  output logic                      o_mret
);
  import rv_pkg::*;

  localparam logic [INST_W-1:0] INST_ECALL  = 32'h0000_0073;
  localparam logic [INST_W-1:0] INST_EBREAK = 32'h0010_0073;
  localparam logic [INST_W-1:0] INST_MRET   = 32'h3020_0073;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_z;
  logic            legal;
  logic            alt;

  function automatic alu_op_e f3_alu(input logic [2:0] f3, input logic alt_op);
    case (f3)
      3'b000:  return alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // raw fields used by the hazard check in every format
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];
  assign o_csr = i_inst[31:20];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_z = {{(XLEN-5){1'b0}}, i_inst[19:15]};  // csr uimm

  assign alt = i_inst[30];

  always_comb begin
    o_ctrl        = '0;
    o_ctrl.mem_op = funct3;
    o_imm         = imm_i;
    o_bren        = 1'b0;
    o_brfunc      = funct3;
    o_jal         = 1'b0;
    o_jalr        = 1'b0;
    o_ecall       = 1'b0;
    o_mret        = 1'b0;
    legal         = 1'b1;
    case (opcode)
      OP_LUI: begin
        o_imm               = imm_u;
        o_ctrl.alu_op       = ALU_LUI;
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_AUIPC, OP_JAL: begin
        o_imm               = (opcode == OP_JAL) ? imm_j : imm_u;
        o_jal               = (opcode == OP_JAL);
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = (opcode == OP_JAL) ? 2'd2 : 2'd1;  // link is pc + 4
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_JALR: begin
        legal               = (funct3 == 3'b000);
        o_jalr              = 1'b1;
        o_ctrl.alu_src1_sel = 1'b1;
        o_ctrl.alu_src2_sel = 2'd2;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_BRANCH: begin
        legal  = (funct3[2:1] != 2'b01);
        o_imm  = imm_b;
        o_bren = 1'b1;
      end
      OP_LOAD: begin
        legal               = (funct3 != 3'b111);
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.mem_ren      = 1'b1;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_STORE: begin
        legal               = !funct3[2];
        o_imm               = imm_s;
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.mem_wen      = 1'b1;
      end
      OP_IMM, OP_IMM32: begin
        if (opcode == OP_IMM32) begin
          legal = (funct3 == 3'b000) || (funct3 == 3'b001 && funct7 == 7'b0) ||
                  (funct3 == 3'b101 && (funct7 == 7'b0 || funct7 == 7'b0100000));
        end else if (funct3 == 3'b001) begin
          legal = (i_inst[31:26] == 6'b0);  // 6-bit shamt
        end else if (funct3 == 3'b101) begin
          legal = (i_inst[31:26] == 6'b0) || (i_inst[31:26] == 6'b010000);
        end
        o_ctrl.alu_op       = f3_alu(funct3, alt && funct3 == 3'b101);
        o_ctrl.alu_src2_sel = 2'd1;
        o_ctrl.word_cut     = (opcode == OP_IMM32);
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_REG, OP_REG32: begin
        legal = (funct7 == 7'b0) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        if (opcode == OP_REG32 && funct3 != 3'b000 && funct3 != 3'b001 &&
            funct3 != 3'b101) begin
          legal = 1'b0;
        end
        o_ctrl.alu_op   = f3_alu(funct3, alt);
        o_ctrl.word_cut = (opcode == OP_REG32);
        o_ctrl.gpr_wen  = 1'b1;
      end
      OP_SYSTEM: begin
        o_imm = imm_z;
        if (funct3 == 3'b000) begin
          case (i_inst)
            INST_ECALL:  o_ecall = 1'b1;
            INST_EBREAK: o_ctrl.ebreak = 1'b1;
            INST_MRET:   o_mret = 1'b1;
            default:     legal = 1'b0;
          endcase
        end else begin
          legal               = (funct3 != 3'b100);
          o_ctrl.alu_src2_sel = funct3[2] ? 2'd1 : 2'd0;  // uimm or rs1
          o_ctrl.gpr_wen      = 1'b1;
          o_ctrl.csr_wen      = 1'b1;
          o_ctrl.csr_inst_sel = 1'b1;
          case (funct3[1:0])
            2'b01:   o_ctrl.csr_op = CSR_WRITE;
            2'b10:   o_ctrl.csr_op = CSR_SET;
            default: o_ctrl.csr_op = CSR_CLEAR;
          endcase
        end
      end
      default: legal = 1'b0;
    endcase

    if (!legal) begin  // nothing may write or redirect
      o_ctrl         = '0;
      o_ctrl.invalid = 1'b1;
      o_bren         = 1'b0;
      o_jal          = 1'b0;
      o_jalr         = 1'b0;
      o_ecall        = 1'b0;
      o_mret         = 1'b0;
    end
  end

endmodule

// ==== rtl/rv_gpr_file.sv ====
// General register file
`timescale 1ns/10ps

module rv_gpr_file (
  input  logic                      i_clk,
  input  logic [rv_pkg::GPR_AW-1:0] i_raddr1,
  output logic [rv_pkg::XLEN-1:0]   o_rdata1,
  input  logic [rv_pkg::GPR_AW-1:0] i_raddr2,
  output logic [rv_pkg::XLEN-1:0]   o_rdata2,
  input  logic                      i_wen,
  input  logic [rv_pkg::GPR_AW-1:0] i_waddr,
  input  logic [rv_pkg::XLEN-1:0]   i_wdata
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [1:2**GPR_AW-1];  // no storage for x0

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== rtl/rv_csr_file.sv ====
// Machine mode CSR file
`timescale 1ns/10ps

module rv_csr_file #(
  parameter logic [rv_pkg::XLEN-1:0] MTVEC_RESET = 64'h8000_0000
) (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic [rv_pkg::CSR_AW-1:0] i_raddr,
  output logic [rv_pkg::XLEN-1:0]   o_rdata,
  input  logic                      i_wen,
  input  logic [rv_pkg::CSR_AW-1:0] i_waddr,
  input  logic [rv_pkg::XLEN-1:0]   i_wdata,
  input  logic                      i_trap,
  input  logic [rv_pkg::XLEN-1:0]   i_epc,
  output logic [rv_pkg::XLEN-1:0]   o_mtvec,
  output logic [rv_pkg::XLEN-1:0]   o_mepc
);
  import rv_pkg::*;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= '0;
      mtvec   <= MTVEC_RESET;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          CSR_MSTATUS: mstatus <= i_wdata;
          CSR_MTVEC:   mtvec   <= i_wdata;
          CSR_MEPC:    mepc    <= i_wdata;
          CSR_MCAUSE:  mcause  <= i_wdata;
          default: ;
        endcase
      end
      // trap comes last, so it wins over writeback
      if (i_trap) begin
        mepc   <= i_epc;
        mcause <= CAUSE_ECALL_M;
      end
    end
  end

  always_comb begin
    case (i_raddr)
      CSR_MSTATUS: o_rdata = mstatus;
      CSR_MTVEC:   o_rdata = mtvec;
      CSR_MEPC:    o_rdata = mepc;
      CSR_MCAUSE:  o_rdata = mcause;
      default:     o_rdata = '0;
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

  a_trap_capture: assert property (@(posedge i_clk) disable iff (i_reset)
    i_trap |=> (mepc == $past(i_epc) && mcause == CAUSE_ECALL_M));

endmodule

// ==== rtl/rv_branch_unit.sv ====
// Branch, jump and trap redirect
`timescale 1ns/10ps

module rv_branch_unit (
  input  logic                    i_valid,
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  input  logic [rv_pkg::XLEN-1:0] i_imm,
  input  logic [rv_pkg::XLEN-1:0] i_rs1data,
  input  logic [rv_pkg::XLEN-1:0] i_rs2data,
  input  logic                    i_bren,
  input  logic [2:0]              i_brfunc,
  input  logic                    i_jal,
  input  logic                    i_jalr,
  input  logic                    i_ecall,
  input  logic                    i_mret,
  input  logic [rv_pkg::XLEN-1:0] i_mtvec,
  input  logic [rv_pkg::XLEN-1:0] i_mepc,
  output rv_pkg::br_bus_t         o_br_bus
);
  import rv_pkg::*;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  logic [XLEN-1:0] pc_rel;
  logic [XLEN-1:0] jalr_sum;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_brfunc)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;
      3'b101:  cond = !lt;
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign pc_rel   = i_pc + i_imm;
  assign jalr_sum = i_rs1data + i_imm;

  always_comb begin
    o_br_bus.taken = i_valid && ((i_bren && cond) || i_jal || i_jalr || i_ecall || i_mret);
    if (i_ecall) begin
      o_br_bus.target = i_mtvec;
    end else if (i_mret) begin
      o_br_bus.target = i_mepc;
    end else if (i_jalr) begin
      o_br_bus.target = {jalr_sum[XLEN-1:1], 1'b0};
    end else begin
      o_br_bus.target = pc_rel;  // branch or jal
    end
  end

endmodule

// ==== rtl/rv_id_stage.sv ====
// Instruction decode stage
`timescale 1ns/10ps

module rv_id_stage #(
  parameter logic [rv_pkg::XLEN-1:0] MTVEC_RESET = 64'h8000_0000
) (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_es_allowin,
  output logic              o_ds_allowin,
  input  logic              i_fs_to_ds_valid,
  input  rv_pkg::fs_to_ds_t i_fs_to_ds_bus,
  output logic              o_ds_to_es_valid,
  output rv_pkg::ds_to_es_t o_ds_to_es_bus,
  output rv_pkg::br_bus_t   o_br_bus,
  input  rv_pkg::ws_to_rf_t i_ws_to_rf_bus,
  input  rv_pkg::stage_rd_t i_es_rd,
  input  rv_pkg::stage_rd_t i_ms_rd,
  input  rv_pkg::stage_rd_t i_ws_rd
);
  import rv_pkg::*;

  logic              ds_valid;
  logic              ds_ready_go;
  logic              fire;
  fs_to_ds_t         ds_pkt;
  logic [GPR_AW-1:0] rs1;
  logic [GPR_AW-1:0] rs2;
  logic [GPR_AW-1:0] rd;
  logic [CSR_AW-1:0] csr;
  logic [XLEN-1:0]   imm;
  logic [XLEN-1:0]   rs1data;
  logic [XLEN-1:0]   rs2data;
  logic [XLEN-1:0]   csrrdata;
  logic [XLEN-1:0]   mtvec;
  logic [XLEN-1:0]   mepc;
  decode_ctrl_t      ctrl;
  logic              bren;
  logic [2:0]        brfunc;
  logic              jal;
  logic              jalr;
  logic              ecall;
  logic              mret;

  // pending write by a later stage to one of our sources
  function automatic logic stage_hit(input stage_rd_t s, input logic [GPR_AW-1:0] r1,
                                     input logic [GPR_AW-1:0] r2, input logic [CSR_AW-1:0] c);
    return ((s.gpr_rd != '0) && (s.gpr_rd == r1 || s.gpr_rd == r2)) ||
           ((s.csr_rd != '0) && (s.csr_rd == c));
  endfunction

  assign ds_ready_go = !(stage_hit(i_es_rd, rs1, rs2, csr) ||
                         stage_hit(i_ms_rd, rs1, rs2, csr) ||
                         stage_hit(i_ws_rd, rs1, rs2, csr));

  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign fire             = o_ds_to_es_valid && i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_pkt <= i_fs_to_ds_bus;
    end
  end

  always_comb begin
    o_ds_to_es_bus.rs1data  = rs1data;
    o_ds_to_es_bus.rs2data  = rs2data;
    o_ds_to_es_bus.csrrdata = csrrdata;
    o_ds_to_es_bus.imm      = imm;
    o_ds_to_es_bus.pc       = ds_pkt.pc;
    o_ds_to_es_bus.rd       = rd;
    o_ds_to_es_bus.csr      = csr;
    o_ds_to_es_bus.ctrl     = ctrl;
  end

  rv_decoder u_decoder (
    .i_inst   (ds_pkt.inst),
    .o_rs1    (rs1),
    .o_rs2    (rs2),
    .o_rd     (rd),
    .o_csr    (csr),
    .o_imm    (imm),
    .o_ctrl   (ctrl),
    .o_bren   (bren),
    .o_brfunc (brfunc),
    .o_jal    (jal),
    .o_jalr   (jalr),
    .o_ecall  (ecall),
    .o_mret   (mret)
  );

  rv_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (rs2),
    .o_rdata2 (rs2data),
    .i_wen    (i_ws_to_rf_bus.gpr_wen),
    .i_waddr  (i_ws_to_rf_bus.gpr_waddr),
    .i_wdata  (i_ws_to_rf_bus.gpr_wdata)
  );

  rv_csr_file #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_csr_file (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_raddr (csr),
    .o_rdata (csrrdata),
    .i_wen   (i_ws_to_rf_bus.csr_wen),
    .i_waddr (i_ws_to_rf_bus.csr_waddr),
    .i_wdata (i_ws_to_rf_bus.csr_wdata),
    .i_trap  (fire && ecall),  // capture once, as it leaves
    .i_epc   (ds_pkt.pc),
    .o_mtvec (mtvec),
    .o_mepc  (mepc)
  );

  rv_branch_unit u_branch_unit (
    .i_valid   (o_ds_to_es_valid),
    .i_pc      (ds_pkt.pc),
    .i_imm     (imm),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_bren    (bren),
    .i_brfunc  (brfunc),
    .i_jal     (jal),
    .i_jalr    (jalr),
    .i_ecall   (ecall),
    .i_mret    (mret),
    .i_mtvec   (mtvec),
    .i_mepc    (mepc),
    .o_br_bus  (o_br_bus)
  );

  // held by execute, so neither packet nor register reads may move
  a_bus_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_ds_to_es_valid && !i_es_allowin) |=> $stable(o_ds_to_es_bus));

  a_taken_valid: assert property (@(posedge i_clk) disable iff (i_reset)
    o_br_bus.taken |-> o_ds_to_es_valid);

endmodule

// ==== verif/tb_id_stage.sv ====
// Decode stage testbench
`timescale 1ns/10ps

module tb_id_stage;
  import rv_pkg::*;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
    logic [GPR_AW-1:0] hz_gpr;  // destination that must stall us
    logic [CSR_AW-1:0] hz_csr;
    logic              bp;      // hold execute allowin low
    logic              chk_imm;
    logic [XLEN-1:0]   imm;
    decode_ctrl_t      ctrl;
    logic [XLEN-1:0]   rs1d;
    logic [XLEN-1:0]   rs2d;
    logic [XLEN-1:0]   csrd;
    logic              taken;
    logic [XLEN-1:0]   target;
  } entry_t;

  localparam logic [3:0] W_GPR = 4'b1000;  // gpr, csr, load, store
  localparam logic [3:0] W_CSR = 4'b1100;
  localparam logic [3:0] W_LD  = 4'b1010;
  localparam logic [3:0] W_ST  = 4'b0001;
  localparam int         WAIT_MAX = 20;

  logic      i_clk = 1'b0;
  logic      i_reset;
  logic      i_es_allowin;
  logic      o_ds_allowin;
  logic      i_fs_to_ds_valid;
  fs_to_ds_t i_fs_to_ds_bus;
  logic      o_ds_to_es_valid;
  ds_to_es_t o_ds_to_es_bus;
  br_bus_t   o_br_bus;
  ws_to_rf_t i_ws_to_rf_bus;
  stage_rd_t i_es_rd;
  stage_rd_t i_ms_rd;
  stage_rd_t i_ws_rd;

  entry_t          tbl[$];
  logic [XLEN-1:0] gpr_m [0:31];
  logic [XLEN-1:0] m_mstatus;
  logic [XLEN-1:0] m_mtvec;
  logic [XLEN-1:0] m_mepc;
  logic [XLEN-1:0] m_mcause;
  logic [XLEN-1:0] next_pc;
  logic [GPR_AW-1:0] pend_gpr;
  logic [CSR_AW-1:0] pend_csr;
  logic              pend_bp;
  int                errors = 0;

  rv_id_stage #(.MTVEC_RESET(64'h8000_0000)) DUT (.*);

  always #50 i_clk = !i_clk;

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic timeout_stop(input string what);
    $display("timed out waiting for %s, %0d errors so far", what, errors);
    $display("ERRORS FOUND");
    $finish;
  endtask

  function automatic logic [XLEN-1:0] csr_model(input logic [CSR_AW-1:0] a);
    case (a)
      CSR_MSTATUS: return m_mstatus;
      CSR_MTVEC:   return m_mtvec;
      CSR_MEPC:    return m_mepc;
      CSR_MCAUSE:  return m_mcause;
      default:     return '0;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic decode_ctrl_t mk(input logic s1, input logic [1:0] s2, input logic word,
      input alu_op_e alu, input logic [3:0] wen, input csr_op_e cop);
    decode_ctrl_t c;
    c              = '0;
    c.alu_src1_sel = s1;
    c.alu_src2_sel = s2;
    c.word_cut     = word;
    c.alu_op       = alu;
    {c.gpr_wen, c.csr_wen, c.mem_ren, c.mem_wen} = wen;
    c.csr_inst_sel = wen[2];
    c.csr_op       = cop;
    return c;
  endfunction

  // one table row with register reads taken from the model
  task automatic add(input logic [31:0] inst, input logic chk, input logic [XLEN-1:0] imm,
      input decode_ctrl_t c, input logic tk, input logic [XLEN-1:0] tgt);
    entry_t e;
    e.inst    = inst;
    e.pc      = next_pc;
    e.hz_gpr  = pend_gpr;
    e.hz_csr  = pend_csr;
    e.bp      = pend_bp;
    e.chk_imm = chk;
    e.imm     = imm;
    e.ctrl    = c;
    if (!c.invalid) e.ctrl.mem_op = inst[14:12];
    e.rs1d    = gpr_m[inst[19:15]];
    e.rs2d    = gpr_m[inst[24:20]];
    e.csrd    = csr_model(inst[31:20]);
    e.taken   = tk;
    e.target  = tgt;
    tbl.push_back(e);
    next_pc   = next_pc + 4;
    pend_gpr  = '0;
    pend_csr  = '0;
    pend_bp   = 1'b0;
  endtask

  task automatic write_rf(input logic gw, input logic [4:0] ga, input logic [XLEN-1:0] gd,
      input logic cw, input logic [CSR_AW-1:0] ca, input logic [XLEN-1:0] cd);
    i_ws_to_rf_bus = '{gw, ga, gd, cw, ca, cd};
    if (gw && ga != 0) gpr_m[ga] = gd;
    if (cw) begin
      case (ca)
        CSR_MSTATUS: m_mstatus = cd;
        CSR_MTVEC:   m_mtvec = cd;
        CSR_MEPC:    m_mepc = cd;
        CSR_MCAUSE:  m_mcause = cd;
        default: ;
      endcase
    end
    @(posedge i_clk);
    #5 i_ws_to_rf_bus = '0;
  endtask

  task automatic run_entry(input entry_t e, input int idx);
    int        n;
    ds_to_es_t held;
    i_fs_to_ds_valid = 1'b1;
    i_fs_to_ds_bus   = '{e.inst, e.pc};
    i_es_allowin     = !e.bp;
    case ($urandom % 3)
      0:       i_es_rd = '{e.hz_gpr, e.hz_csr};
      1:       i_ms_rd = '{e.hz_gpr, e.hz_csr};
      default: i_ws_rd = '{e.hz_gpr, e.hz_csr};
    endcase
    n = 0;
    while (!o_ds_allowin) begin
      if (n == WAIT_MAX) timeout_stop("decode allowin");
      @(posedge i_clk);
      #5 n++;
    end
    @(posedge i_clk);
    #5 i_fs_to_ds_valid = 1'b0;
    if (e.hz_gpr != 0 || e.hz_csr != 0) begin
      repeat (2) begin
        @(negedge i_clk);
        check_eq(64'(o_ds_to_es_valid), 64'd0, $sformatf("entry %0d valid in hazard", idx));
        check_eq(64'(o_ds_allowin), 64'd0, $sformatf("entry %0d allowin in hazard", idx));
      end
      @(posedge i_clk);
      #5;
      i_es_rd = '0;
      i_ms_rd = '0;
      i_ws_rd = '0;
    end
    n = 0;
    @(negedge i_clk);
    while (!o_ds_to_es_valid) begin
      if (n == WAIT_MAX) timeout_stop("decode output valid");
      @(negedge i_clk);
      n++;
    end
    if (e.hz_gpr == 0 && e.hz_csr == 0) check_eq(64'(n), 64'd0, "latency");
    check_eq(o_ds_to_es_bus.pc, e.pc, $sformatf("entry %0d pc", idx));
    if (e.chk_imm) check_eq(o_ds_to_es_bus.imm, e.imm, $sformatf("entry %0d imm", idx));
    check_eq(64'(o_ds_to_es_bus.rd), 64'(e.inst[11:7]), $sformatf("entry %0d rd", idx));
    check_eq(64'(o_ds_to_es_bus.csr), 64'(e.inst[31:20]), $sformatf("entry %0d csr", idx));
    check_eq(64'(o_ds_to_es_bus.ctrl), 64'(e.ctrl), $sformatf("entry %0d ctrl", idx));
    check_eq(o_ds_to_es_bus.rs1data, e.rs1d, $sformatf("entry %0d rs1data", idx));
    check_eq(o_ds_to_es_bus.rs2data, e.rs2d, $sformatf("entry %0d rs2data", idx));
    check_eq(o_ds_to_es_bus.csrrdata, e.csrd, $sformatf("entry %0d csrrdata", idx));
    check_eq(64'(o_br_bus.taken), 64'(e.taken), $sformatf("entry %0d taken", idx));
    if (e.taken) check_eq(o_br_bus.target, e.target, $sformatf("entry %0d target", idx));
    if (e.bp) begin
      held = o_ds_to_es_bus;
      check_eq(64'(o_ds_allowin), 64'd0, $sformatf("entry %0d allowin held", idx));
      @(posedge i_clk);
      @(negedge i_clk);
      check_eq(64'(o_ds_to_es_bus == held), 64'd1, $sformatf("entry %0d bus stable", idx));
      @(posedge i_clk);
      #5 i_es_allowin = 1'b1;
    end
    @(posedge i_clk);  // fire
    @(negedge i_clk);
    check_eq(64'(o_ds_to_es_valid), 64'd0, $sformatf("entry %0d valid after fire", idx));
    check_eq(64'(o_br_bus.taken), 64'd0, $sformatf("entry %0d taken after fire", idx));
  endtask

  task automatic build_table();
    decode_ctrl_t    nul;
    decode_ctrl_t    inv;
    logic [XLEN-1:0] ecall_pc;
    nul         = '0;
    inv         = '0;
    inv.invalid = 1'b1;
    add(enc_i(12'hFFB, 5'd1, 3'd0, 5'd6, OP_IMM), 1, -64'd5,
        mk(0, 2'd1, 0, ALU_ADD, W_GPR, CSR_NONE), 0, 0);
    pend_bp = 1'b1;  // x0 source under back-pressure
    add(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd7, OP_REG), 0, 0,
        mk(0, 2'd0, 0, ALU_ADD, W_GPR, CSR_NONE), 0, 0);
    pend_gpr = 5'd4;
    add(enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd8, OP_REG), 0, 0,
        mk(0, 2'd0, 0, ALU_SUB, W_GPR, CSR_NONE), 0, 0);
    add(enc_i(12'd7, 5'd1, 3'd0, 5'd9, OP_IMM32), 1, 64'd7,
        mk(0, 2'd1, 1, ALU_ADD, W_GPR, CSR_NONE), 0, 0);
    add(enc_i(12'h403, 5'd3, 3'd5, 5'd10, OP_IMM), 1, 64'h403,
        mk(0, 2'd1, 0, ALU_SRA, W_GPR, CSR_NONE), 0, 0);
    add({20'hFFFFF, 5'd11, OP_LUI}, 1, 64'hFFFF_FFFF_FFFF_F000,
        mk(0, 2'd1, 0, ALU_LUI, W_GPR, CSR_NONE), 0, 0);
    add({20'h12345, 5'd12, OP_AUIPC}, 1, 64'h1234_5000,
        mk(1, 2'd1, 0, ALU_ADD, W_GPR, CSR_NONE), 0, 0);
    add(enc_i(12'd16, 5'd1, 3'd3, 5'd13, OP_LOAD), 1, 64'd16,
        mk(0, 2'd1, 0, ALU_ADD, W_LD, CSR_NONE), 0, 0);
    add(enc_s(12'hFF8, 5'd4, 5'd1, 3'd3), 1, -64'd8,
        mk(0, 2'd1, 0, ALU_ADD, W_ST, CSR_NONE), 0, 0);
    add(enc_b(13'd16, 5'd2, 5'd1, 3'd0), 1, 64'd16, nul, gpr_m[1] == gpr_m[2], next_pc + 16);
    add(enc_b(13'd16, 5'd2, 5'd1, 3'd1), 1, 64'd16, nul, gpr_m[1] != gpr_m[2], next_pc + 16);
    add(enc_b(13'h1FE0, 5'd4, 5'd3, 3'd4), 1, -64'd32, nul,
        $signed(gpr_m[3]) < $signed(gpr_m[4]), next_pc - 32);
    add(enc_b(13'd16, 5'd4, 5'd3, 3'd5), 1, 64'd16, nul,
        $signed(gpr_m[3]) >= $signed(gpr_m[4]), next_pc + 16);
    add(enc_b(13'd16, 5'd4, 5'd3, 3'd6), 1, 64'd16, nul, gpr_m[3] < gpr_m[4], next_pc + 16);
    add(enc_b(13'd8, 5'd4, 5'd3, 3'd7), 1, 64'd8, nul, gpr_m[3] >= gpr_m[4], next_pc + 8);
    add(enc_j(21'd2048, 5'd1), 1, 64'd2048,
        mk(1, 2'd2, 0, ALU_ADD, W_GPR, CSR_NONE), 1, next_pc + 2048);
    add(enc_i(12'd5, 5'd4, 3'd0, 5'd0, OP_JALR), 1, 64'd5,
        mk(1, 2'd2, 0, ALU_ADD, W_GPR, CSR_NONE), 1, (gpr_m[4] + 5) & ~64'd1);
    add(32'hFFFF_FFFF, 0, 0, inv, 0, 0);
    add(enc_i(CSR_MSTATUS, 5'd5, 3'd1, 5'd14, OP_SYSTEM), 1, 64'd5,
        mk(0, 2'd0, 0, ALU_ADD, W_CSR, CSR_WRITE), 0, 0);
    add(enc_i(CSR_MTVEC, 5'd3, 3'd6, 5'd15, OP_SYSTEM), 1, 64'd3,
        mk(0, 2'd1, 0, ALU_ADD, W_CSR, CSR_SET), 0, 0);
    pend_csr = CSR_MSTATUS;
    add(enc_i(CSR_MSTATUS, 5'd6, 3'd3, 5'd20, OP_SYSTEM), 1, 64'd6,
        mk(0, 2'd0, 0, ALU_ADD, W_CSR, CSR_CLEAR), 0, 0);
    pend_gpr = 5'd6;
    add(enc_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd16, OP_REG), 0, 0,
        mk(0, 2'd0, 0, ALU_ADD, W_GPR, CSR_NONE), 0, 0);
    ecall_pc = next_pc;
    add(32'h0000_0073, 1, 64'd0, nul, 1, m_mtvec);
    m_mepc   = ecall_pc;  // trap capture at fire
    m_mcause = 64'd11;
    pend_csr = CSR_MEPC;
    pend_bp  = 1'b1;
    add(enc_i(CSR_MEPC, 5'd0, 3'd2, 5'd17, OP_SYSTEM), 1, 64'd0,
        mk(0, 2'd0, 0, ALU_ADD, W_CSR, CSR_SET), 0, 0);
    add(enc_i(CSR_MCAUSE, 5'd0, 3'd2, 5'd18, OP_SYSTEM), 1, 64'd0,
        mk(0, 2'd0, 0, ALU_ADD, W_CSR, CSR_SET), 0, 0);
    add(32'h3020_0073, 1, 64'd0, nul, 1, ecall_pc);
  endtask

  initial begin
    int unsigned seed_val;
    seed_val         = $urandom(31839);
    i_reset          = 1'b1;
    i_es_allowin     = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds_bus   = '0;
    i_ws_to_rf_bus   = '0;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    gpr_m[0]         = '0;
    m_mstatus        = '0;
    m_mtvec          = 64'h8000_0000;
    m_mepc           = '0;
    m_mcause         = '0;
    next_pc          = 64'h0000_0000_8000_1000;
    pend_gpr         = '0;
    pend_csr         = '0;
    pend_bp          = 1'b0;
    repeat (8) @(posedge i_clk);
    #5 i_reset = 1'b0;
    @(negedge i_clk);
    check_eq(64'(o_ds_to_es_valid), 64'd0, "valid after reset");
    check_eq(64'(o_br_bus.taken), 64'd0, "taken after reset");
    check_eq(64'(o_ds_allowin), 64'd1, "allowin after reset");
    @(posedge i_clk);
    #5;
    for (int r = 0; r < 32; r++) begin  // x0 write must be dropped
      write_rf(1'b1, 5'(r), {$urandom, $urandom}, 1'b0, '0, '0);
    end
    write_rf(1'b1, 5'd2, gpr_m[1], 1'b0, '0, '0);
    write_rf(1'b1, 5'd3, {1'b1, 31'($urandom), $urandom}, 1'b1, CSR_MSTATUS,
             {$urandom, $urandom});
    write_rf(1'b1, 5'd4, {1'b0, 31'($urandom), $urandom}, 1'b1, CSR_MTVEC,
             {$urandom, $urandom} & ~64'd3);
    build_table();
    foreach (tbl[i]) begin
      @(posedge i_clk);
      #5 run_entry(tbl[i], i);
    end
    $display("decode checks complete with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_gpr_file.sv
rtl/rv_csr_file.sv
rtl/rv_branch_unit.sv
rtl/rv_id_stage.sv
verif/tb_id_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_id_stage -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
